/* Makefile */
TOP = tb_mips_pipeline

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+include
hdl/mips_pkg.sv
hdl/control_unit.sv
hdl/regfile.sv
hdl/alu.sv
hdl/jump_unit.sv
hdl/mips_pipeline.sv
sim/mips_pipeline_properties.sv
sim/tb_mips_pipeline.sv

/* hdl/alu.sv */
// Integer ALU for the core; no overflow detection and slt compares as signed.
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  alu_cmd_e cmd,
  output word_t    result,
  output logic     zero
);

  always_comb begin
    case (cmd)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // Signed compare.
      ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: result = '0;
    endcase
  end

  // Branch compare uses the subtract result.
  assign zero = (result == '0);

endmodule

/* hdl/control_unit.sv */
// Combinational decoder; unknown codes and the jump instructions decode to a bubble with no writes.
`timescale 1ns/1ps

module control_unit import mips_pkg::*; (
  input  instr_t   instr,
  output logic     reg_write,
  output logic     mem_to_reg,
  output logic     mem_write,
  output logic     branch,
  output logic     branch_ne,
  output alu_cmd_e alu_cmd,
  output logic     alu_src,
  output logic     reg_dst
);

  always_comb begin
    // Bubble unless a known code says otherwise.
    reg_write  = 1'b0;
    mem_to_reg = 1'b0;
    mem_write  = 1'b0;
    branch     = 1'b0;
    branch_ne  = 1'b0;
    alu_cmd    = ALU_ADD;
    alu_src    = 1'b0;
    reg_dst    = 1'b0;
    case (instr.r.opcode)
      OP_RTYPE: begin
        reg_dst = 1'b1;
        case (instr.r.funct)
          FN_ADD: begin
            reg_write = 1'b1;
            alu_cmd   = ALU_ADD;
          end
          FN_SUB: begin
            reg_write = 1'b1;
            alu_cmd   = ALU_SUB;
          end
          FN_AND: begin
            reg_write = 1'b1;
            alu_cmd   = ALU_AND;
          end
          FN_OR: begin
            reg_write = 1'b1;
            alu_cmd   = ALU_OR;
          end
          FN_SLT: begin
            reg_write = 1'b1;
            alu_cmd   = ALU_SLT;
          end
          // jr and unknown functions write nothing.
          default: reg_write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
      end
      OP_LW: begin
        reg_write  = 1'b1;
        mem_to_reg = 1'b1;
        alu_src    = 1'b1;
      end
      OP_SW: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
      end
      OP_BEQ: begin
        branch  = 1'b1;
        alu_cmd = ALU_SUB;
      end
      OP_BNE: begin
        branch    = 1'b1;
        branch_ne = 1'b1;
        alu_cmd   = ALU_SUB;
      end
      default: alu_cmd = ALU_ADD;
    endcase
  end

endmodule

/* hdl/jump_unit.sv */
// Decode-stage jump logic; the caller supplies the link register index and one delay slot always executes.
`timescale 1ns/1ps

module jump_unit import mips_pkg::*; (
  input  instr_t instr,
  input  word_t  pc_plus4,
  input  word_t  rs_data,
  output logic   redirect,
  output word_t  target,
  output logic   link,
  output word_t  link_value
);

  logic is_j;
  logic is_jr;

  assign is_j  = (instr.r.opcode == OP_J) || (instr.r.opcode == OP_JAL);
  assign is_jr = (instr.r.opcode == OP_RTYPE) && (instr.r.funct == FN_JR);
  assign link  = (instr.r.opcode == OP_JAL);

  assign redirect = is_j || is_jr;

  // Pseudo-direct target from the delay slot region.
  assign target = is_jr ? rs_data : {pc_plus4[31:28], instr.r[25:0], 2'b00};

  // Return address skips the delay slot.
  assign link_value = pc_plus4 + 32'd4;

endmodule

/* hdl/mips_pipeline.sv */
// Core has no interlocks or forwarding and relies on nops for data hazards, branch slots and jump slots.
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_pipeline import mips_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output word_t instr_addr,
  input  word_t instr,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  input  word_t data_rdata
);

  word_t pc;
  word_t pc_plus4;
  word_t pc_next;

  instr_t     instr_id;
  word_t      pc_plus4_id;
  logic       reg_write_id, mem_to_reg_id, mem_write_id;
  logic       branch_id, branch_ne_id, alu_src_id, reg_dst_id;
  alu_cmd_e   alu_cmd_id;
  word_t      rs_data_id, rt_data_id, imm_id;
  logic       redirect_id, link_id;
  word_t      jump_target_id, link_value_id;

  logic       reg_write_ex, mem_to_reg_ex, mem_write_ex;
  logic       branch_ex, branch_ne_ex, alu_src_ex, reg_dst_ex, link_ex;
  alu_cmd_e   alu_cmd_ex;
  word_t      rs_data_ex, rt_data_ex, imm_ex, pc_plus4_ex, link_value_ex;
  logic [4:0] rt_ex, rd_ex, dst_ex;
  word_t      alu_b_ex, alu_result_ex, result_ex, branch_target_ex;
  logic       zero_ex;

  logic       reg_write_mem, mem_to_reg_mem, mem_write_mem;
  logic       branch_mem, branch_ne_mem, zero_mem, take_branch_mem;
  word_t      result_mem, wdata_mem, branch_target_mem;
  logic [4:0] dst_mem;

  logic       reg_write_wb, mem_to_reg_wb;
  word_t      result_wb, read_data_wb, wr_data_wb;
  logic [4:0] dst_wb;

  // Fetch. A jump in decode wins over a branch in memory.
  assign instr_addr = pc;
  assign pc_plus4   = pc + 32'd4;

  always_comb begin
    if (redirect_id) begin
      pc_next = jump_target_id;
    end else if (take_branch_mem) begin
      pc_next = branch_target_mem;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= `MIPS_RESET_PC;
      instr_id <= '0;
    end else begin
      pc       <= pc_next;
      instr_id <= instr;
    end
    pc_plus4_id <= pc_plus4;
  end

  // Decode.
  control_unit i_control_unit (
    .instr      (instr_id),
    .reg_write  (reg_write_id),
    .mem_to_reg (mem_to_reg_id),
    .mem_write  (mem_write_id),
    .branch     (branch_id),
    .branch_ne  (branch_ne_id),
    .alu_cmd    (alu_cmd_id),
    .alu_src    (alu_src_id),
    .reg_dst    (reg_dst_id)
  );

  regfile i_regfile (
    .clk     (clk),
    .rs_addr (instr_id.r.rs),
    .rt_addr (instr_id.r.rt),
    .rs_data (rs_data_id),
    .rt_data (rt_data_id),
    .wr_addr (dst_wb),
    .wr_data (wr_data_wb),
    .wr_en   (reg_write_wb)
  );

  jump_unit i_jump_unit (
    .instr      (instr_id),
    .pc_plus4   (pc_plus4_id),
    .rs_data    (rs_data_id),
    .redirect   (redirect_id),
    .target     (jump_target_id),
    .link       (link_id),
    .link_value (link_value_id)
  );

  assign imm_id = {{16{instr_id.i.imm[15]}}, instr_id.i.imm};

  // jal enters execute as a register write to the link register.
  always_ff @(posedge clk) begin
    if (rst) begin
      reg_write_ex  <= 1'b0;
      mem_to_reg_ex <= 1'b0;
      mem_write_ex  <= 1'b0;
      branch_ex     <= 1'b0;
      branch_ne_ex  <= 1'b0;
      alu_src_ex    <= 1'b0;
      reg_dst_ex    <= 1'b0;
      link_ex       <= 1'b0;
      alu_cmd_ex    <= ALU_ADD;
    end else begin
      reg_write_ex  <= reg_write_id | link_id;
      mem_to_reg_ex <= mem_to_reg_id;
      mem_write_ex  <= mem_write_id;
      branch_ex     <= branch_id;
      branch_ne_ex  <= branch_ne_id;
      alu_src_ex    <= alu_src_id;
      reg_dst_ex    <= reg_dst_id | link_id;
      link_ex       <= link_id;
      alu_cmd_ex    <= alu_cmd_id;
    end
    rs_data_ex    <= rs_data_id;
    rt_data_ex    <= rt_data_id;
    imm_ex        <= imm_id;
    pc_plus4_ex   <= pc_plus4_id;
    link_value_ex <= link_value_id;
    rt_ex         <= instr_id.r.rt;
    rd_ex         <= link_id ? `MIPS_LINK_REG : instr_id.r.rd;
  end

  // Execute.
  assign dst_ex   = reg_dst_ex ? rd_ex : rt_ex;
  assign alu_b_ex = alu_src_ex ? imm_ex : rt_data_ex;

  alu i_alu (
    .a      (rs_data_ex),
    .b      (alu_b_ex),
    .cmd    (alu_cmd_ex),
    .result (alu_result_ex),
    .zero   (zero_ex)
  );

  assign result_ex        = link_ex ? link_value_ex : alu_result_ex;
  assign branch_target_ex = pc_plus4_ex + {imm_ex[29:0], 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_write_mem  <= 1'b0;
      mem_to_reg_mem <= 1'b0;
      mem_write_mem  <= 1'b0;
      branch_mem     <= 1'b0;
      branch_ne_mem  <= 1'b0;
    end else begin
      reg_write_mem  <= reg_write_ex;
      mem_to_reg_mem <= mem_to_reg_ex;
      mem_write_mem  <= mem_write_ex;
      branch_mem     <= branch_ex;
      branch_ne_mem  <= branch_ne_ex;
    end
    zero_mem          <= zero_ex;
    result_mem        <= result_ex;
    wdata_mem         <= rt_data_ex;
    dst_mem           <= dst_ex;
    branch_target_mem <= branch_target_ex;
  end

  // Memory access and branch decision.
  assign data_addr  = result_mem;
  assign data_wdata = wdata_mem;
  assign data_we    = mem_write_mem;

  assign take_branch_mem = branch_mem & (branch_ne_mem ? ~zero_mem : zero_mem);

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_write_wb  <= 1'b0;
      mem_to_reg_wb <= 1'b0;
    end else begin
      reg_write_wb  <= reg_write_mem;
      mem_to_reg_wb <= mem_to_reg_mem;
    end
    result_wb    <= result_mem;
    read_data_wb <= data_rdata;
    dst_wb       <= dst_mem;
  end

  // Writeback.
  assign wr_data_wb = mem_to_reg_wb ? read_data_wb : result_wb;

endmodule

/* hdl/mips_pkg.sv */
// Types for the MIPS subset core; only the opcodes and functions listed here are decoded.
package mips_pkg;

  typedef logic [31:0] word_t;

  // Primary opcodes, standard MIPS encoding.
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // Function field of R-type words.
  typedef enum logic [5:0] {
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_cmd_e;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // One instruction word, read as R or I format.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

endpackage

/* hdl/regfile.sv */
// 32x32 register file with asynchronous reads and no reset; a read during a write sees the old value.
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
  input  logic       clk,
  input  logic [4:0] rs_addr,
  input  logic [4:0] rt_addr,
  output word_t      rs_data,
  output word_t      rt_data,
  input  logic [4:0] wr_addr,
  input  word_t      wr_data,
  input  logic       wr_en
);

  word_t regs [32];

  // Register zero always reads as zero.
  assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

/* include/mips_settings.svh */
// Reset vector and link register shared by the core and the testbench; the reset PC must be word aligned.
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Address of the first fetch after reset.
`define MIPS_RESET_PC 32'h0000_0000

// Register written by jal.
`define MIPS_LINK_REG 5'd31

`endif

/* sim/mips_pipeline_properties.sv */
// Memory interface checks for the core; every fetch and store address is expected to be word aligned.
`timescale 1ns/1ps

module mips_pipeline_properties import mips_pkg::*; (
  input logic  clk,
  input logic  rst,
  input word_t instr_addr,
  input word_t data_addr,
  input logic  data_we
);

  // Stage registers are cleared during reset.
  we_in_reset: assert property (@(posedge clk) rst |=> !data_we)
    else $error("data_we high after a reset cycle");

  // Bubbles need three cycles to drain out of the pipe.
  we_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !data_we ##1 !data_we ##1 !data_we)
    else $error("data_we high within three cycles of reset release");

  fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    instr_addr[1:0] == 2'b00)
    else $error("instr_addr not word aligned");

  store_aligned: assert property (@(posedge clk) disable iff (rst)
    data_we |-> data_addr[1:0] == 2'b00)
    else $error("data_addr not word aligned on a store");

endmodule

bind mips_pipeline mips_pipeline_properties i_properties (.*);

/* sim/tb_mips_pipeline.sv */
// Memories hold 256 words and answer combinationally; programs must pad every hazard and delay slot.
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips_pipeline import mips_pkg::*; ();

  localparam word_t MARKER = 32'h0000_03fc;
  localparam int MAX_CYCLES = 3000;

  logic   clk;
  logic   rst;
  word_t  instr_addr, instr, data_addr, data_wdata, data_rdata;
  logic   data_we;
  instr_t imem [256];
  word_t  dmem [256];
  word_t  model_mem [256];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  int     pa;
  int     store_idx = 0;
  int     cycles = 0;
  int     seed = 92;
  logic   done;
  string  test_name = "none";

  mips_pipeline i_dut (
    .clk        (clk),
    .rst        (rst),
    .instr_addr (instr_addr),
    .instr      (instr),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_rdata (data_rdata)
  );

  assign instr      = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Instruction word assemblers.
  function automatic instr_t rtype(funct_e fn, logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
    instr_t w;
    w.r.opcode = OP_RTYPE;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = 5'd0;
    w.r.funct  = fn;
    return w;
  endfunction

  function automatic instr_t itype(opcode_e op, logic [4:0] rt, logic [4:0] rs,
                                   logic [15:0] imm);
    instr_t w;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic instr_t jtype(opcode_e op, logic [25:0] index);
    instr_t w;
    w = {op, index};
    return w;
  endfunction

  function automatic funct_e pick_funct(logic [2:0] sel);
    case (sel)
      3'd0, 3'd5: return FN_ADD;
      3'd1, 3'd6: return FN_SUB;
      3'd2, 3'd7: return FN_AND;
      3'd3:       return FN_OR;
      default:    return FN_SLT;
    endcase
  endfunction

  // Sequential model with delay slots; records every store in order.
  function automatic void iss_run();
    word_t  regs [32];
    word_t  pc, next_pc, pend_pc, imm, a, b, addr;
    int     pend_n, steps;
    instr_t w;
    logic   stop;
    regs    = '{default: '0};
    pc      = `MIPS_RESET_PC;
    pend_pc = '0;
    pend_n  = 0;
    steps   = 0;
    stop    = 1'b0;
    while (!stop && steps < 2000) begin
      w       = imem[pc[9:2]];
      a       = regs[w.r.rs];
      b       = regs[w.r.rt];
      imm     = {{16{w.i.imm[15]}}, w.i.imm};
      addr    = a + imm;
      next_pc = pc + 32'd4;
      if (pend_n > 0) begin
        pend_n--;
        if (pend_n == 0) next_pc = pend_pc;
      end
      case (w.r.opcode)
        OP_RTYPE: begin
          case (w.r.funct)
            FN_ADD: regs[w.r.rd] = a + b;
            FN_SUB: regs[w.r.rd] = a - b;
            FN_AND: regs[w.r.rd] = a & b;
            FN_OR:  regs[w.r.rd] = a | b;
            FN_SLT: regs[w.r.rd] = word_t'($signed(a) < $signed(b));
            FN_JR: begin
              pend_pc = a;
              pend_n  = 1;
            end
            default: ;
          endcase
        end
        OP_ADDI: regs[w.i.rt] = addr;
        OP_LW:   regs[w.i.rt] = model_mem[addr[9:2]];
        OP_SW: begin
          model_mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          if (addr == MARKER) stop = 1'b1;
        end
        OP_BEQ, OP_BNE: begin
          if ((a == b) == (w.r.opcode == OP_BEQ)) begin
            pend_pc = pc + 32'd4 + (imm << 2);
            pend_n  = 3;
          end
        end
        OP_J, OP_JAL: begin
          if (w.r.opcode == OP_JAL) regs[`MIPS_LINK_REG] = pc + 32'd8;
          pend_pc = ((pc + 32'd4) & 32'hf000_0000) | {4'd0, w.r[25:0], 2'b00};
          pend_n  = 1;
        end
        default: ;
      endcase
      regs[0] = '0;
      pc      = next_pc;
      steps++;
    end
  endfunction

  task automatic check_addr(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("ERR %s address: expected %08h, actual %08h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_data(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("ERR %s store data: expected %08h, actual %08h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "store data mismatch");
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
      $display("ERR %s store count: expected %0d, actual %0d", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "store count mismatch");
    end
  endtask

  // Stores are compared away from the clock edge.
  always @(negedge clk) begin
    if (!rst && data_we) begin
      if (store_idx < exp_addr.size()) begin
        check_addr(test_name, exp_addr[store_idx], data_addr);
        check_data(test_name, exp_data[store_idx], data_wdata);
        dmem[data_addr[9:2]] = data_wdata;
        if (data_addr == MARKER) done = 1'b1;
      end
      // Stores past the last expected one show up in the count.
      store_idx++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
    end
  end

  task automatic emit(instr_t w, int gap);
    imem[pa[7:0]] = w;
    pa++;
    repeat (gap) begin
      imem[pa[7:0]] = '0;
      pa++;
    end
  endtask

  // Marker store, then a jump to itself.
  task automatic end_program();
    emit(itype(OP_SW, 5'd0, 5'd0, MARKER[15:0]), 0);
    emit(jtype(OP_J, 26'(pa)), 1);
  endtask

  task automatic start_program();
    @(posedge clk);
    #0.5;
    rst = 1'b1;
    for (int i = 0; i < 256; i++) imem[i[7:0]] = '0;
    pa = 0;
  endtask

  task automatic run_program(string name);
    test_name = name;
    model_mem = dmem;
    exp_addr.delete();
    exp_data.delete();
    iss_run();
    store_idx = 0;
    done      = 1'b0;
    repeat (3) @(posedge clk);
    #0.5;
    rst = 1'b0;
    check_addr({name, " reset pc"}, `MIPS_RESET_PC, instr_addr);
    while (!done) @(posedge clk);
    repeat (6) @(posedge clk);
    check_count(name, exp_addr.size(), store_idx);
  endtask

  initial begin
    int r;
    rst  = 1'b1;
    done = 1'b0;
    pa   = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = '0;
      dmem[i[7:0]] = (word_t'(i) << 2) * 32'h9e37_79b9 + 32'h1357_2468;
    end

    // ALU operations, negative operands and a write to r0.
    start_program();
    emit(itype(OP_ADDI, 5'd1, 5'd0, 16'd100), 3);
    emit(itype(OP_ADDI, 5'd2, 5'd0, 16'hfff9), 3);
    emit(itype(OP_ADDI, 5'd0, 5'd0, 16'd55), 3);
    emit(rtype(FN_ADD, 5'd3, 5'd1, 5'd2), 3);
    emit(rtype(FN_SUB, 5'd4, 5'd2, 5'd1), 3);
    emit(rtype(FN_AND, 5'd5, 5'd1, 5'd2), 3);
    emit(rtype(FN_OR, 5'd6, 5'd1, 5'd2), 3);
    emit(rtype(FN_SLT, 5'd7, 5'd2, 5'd1), 3);
    emit(rtype(FN_SLT, 5'd8, 5'd1, 5'd2), 3);
    for (int i = 0; i < 9; i++) emit(itype(OP_SW, 5'(i), 5'd0, 16'(32'h100 + 4 * i)), 0);
    end_program();
    run_program("alu");

    // Load, store and reload.
    start_program();
    emit(itype(OP_ADDI, 5'd1, 5'd0, 16'h0040), 3);
    emit(itype(OP_LW, 5'd2, 5'd1, 16'd0), 3);
    emit(itype(OP_LW, 5'd3, 5'd1, 16'd4), 3);
    emit(rtype(FN_ADD, 5'd4, 5'd2, 5'd3), 3);
    emit(itype(OP_SW, 5'd4, 5'd1, 16'd8), 0);
    emit(itype(OP_LW, 5'd5, 5'd1, 16'd8), 3);
    emit(itype(OP_ADDI, 5'd5, 5'd5, 16'd1), 3);
    emit(itype(OP_SW, 5'd5, 5'd1, 16'd12), 0);
    emit(itype(OP_SW, 5'd2, 5'd1, 16'd16), 0);
    end_program();
    run_program("load_store");

    // A taken branch skips the one store after its three slots.
    start_program();
    emit(itype(OP_ADDI, 5'd1, 5'd0, 16'd5), 3);
    emit(itype(OP_ADDI, 5'd2, 5'd0, 16'd5), 3);
    emit(itype(OP_ADDI, 5'd3, 5'd0, 16'd9), 3);
    emit(itype(OP_BEQ, 5'd2, 5'd1, 16'd4), 3);
    emit(itype(OP_SW, 5'd3, 5'd0, 16'h0080), 0);
    emit(itype(OP_BEQ, 5'd3, 5'd1, 16'd4), 3);
    emit(itype(OP_SW, 5'd1, 5'd0, 16'h0084), 0);
    emit(itype(OP_BNE, 5'd3, 5'd1, 16'd4), 3);
    emit(itype(OP_SW, 5'd2, 5'd0, 16'h0088), 0);
    emit(itype(OP_BNE, 5'd2, 5'd1, 16'd4), 3);
    emit(itype(OP_SW, 5'd3, 5'd0, 16'h008c), 0);
    emit(itype(OP_SW, 5'd1, 5'd0, 16'h0090), 0);
    end_program();
    run_program("branch");

    // Call a subroutine at word 128 and return through jr.
    start_program();
    emit(itype(OP_ADDI, 5'd1, 5'd0, 16'd11), 3);
    emit(jtype(OP_JAL, 26'd128), 1);
    emit(itype(OP_SW, `MIPS_LINK_REG, 5'd0, 16'h0060), 0);
    emit(itype(OP_SW, 5'd2, 5'd0, 16'h0064), 0);
    emit(jtype(OP_J, 26'(pa + 3)), 1);
    emit(itype(OP_SW, 5'd1, 5'd0, 16'h0068), 0);
    emit(itype(OP_SW, 5'd1, 5'd0, 16'h006c), 0);
    end_program();
    pa = 128;
    emit(itype(OP_ADDI, 5'd2, 5'd1, 16'd1), 3);
    emit(rtype(FN_JR, 5'd0, `MIPS_LINK_REG, 5'd0), 1);
    run_program("jump");

    // Random straight-line program over r1 to r8.
    start_program();
    for (int i = 1; i < 9; i++) begin
      r = $random(seed);
      emit(itype(OP_ADDI, 5'(i), 5'd0, r[15:0]), 3);
    end
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: emit(rtype(pick_funct(r[15:13]), 5'd1 + {2'b00, r[4:2]},
                         5'd1 + {2'b00, r[7:5]}, 5'd1 + {2'b00, r[19:17]}), 3);
        2'd1: emit(itype(OP_ADDI, 5'd1 + {2'b00, r[4:2]}, 5'd1 + {2'b00, r[7:5]},
                         r[31:16]), 3);
        2'd2: emit(itype(OP_LW, 5'd1 + {2'b00, r[4:2]}, 5'd0,
                         16'h0100 + {9'd0, r[12:8], 2'b00}), 3);
        default: emit(itype(OP_SW, 5'd1 + {2'b00, r[4:2]}, 5'd0,
                            16'h0100 + {9'd0, r[12:8], 2'b00}), 0);
      endcase
    end
    for (int i = 1; i < 9; i++) emit(itype(OP_SW, 5'(i), 5'd0, 16'(32'h180 + 4 * i)), 0);
    end_program();
    run_program("random");

    $display("*** PASSED ***");
    $finish;
  end

endmodule
